// ==== cctv_top.f ====
design/cctv_pkg.sv
design/camera_capture.sv
design/frame_store.sv
design/motion_detector.sv
design/vga_timing.sv
design/vga_pixel_out.sv
design/cctv_top.sv
tb/tb_cctv.sv

// ==== design/camera_capture.sv ====
`timescale 1ns/1ns

module camera_capture import cctv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cam_byte_t cam_data,
    input  logic      cam_href,
    input  logic      cam_vsync,
    input  logic      cam_pixel_strobe,
    output logic      pix_we,
    output pix_addr_t pix_addr,
    output gray_t     pix_gray,
    output logic      write_sel,
    output logic      frame_done
);

    capture_state_t state;
    cam_byte_t      first_byte;             // Held R5 and G high 3
    logic           vsync_d;
    logic           vsync_rise;
    logic           byte_take;
    gray_t          r4;
    gray_t          g4;
    gray_t          b4;
    logic [5:0]     gray_sum;               // r + 2g + b, at most 60

    assign vsync_rise = cam_vsync & ~vsync_d;
    assign byte_take  = cam_pixel_strobe & cam_href; // Only bytes inside a line count

    // RGB565 cut to RGB444
    assign r4       = first_byte[7:4];
    assign g4       = {first_byte[2:0], cam_data[7]};
    assign b4       = cam_data[4:1];
    assign gray_sum = {2'b00, r4} + {1'b0, g4, 1'b0} + {2'b00, b4};

    // Frame boundary and ping-pong select
    always_ff @(posedge clk) begin
        vsync_d <= cam_vsync;                // Edge sampler
        if (rst) begin
            frame_done <= 1'b0;
            write_sel  <= 1'b0;
        end else begin
            frame_done <= vsync_rise;        // Pulse one cycle after the edge
            if (vsync_rise)
                write_sel <= ~write_sel;     // Swap buffers with frame_done
        end
    end

    //////////////////////////////
    // Byte pairing FSM and write address
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= WAIT_FRAME;
            pix_we   <= 1'b0;
            pix_addr <= '0;
        end else begin
            pix_we <= 1'b0;
            if (pix_we)
                pix_addr <= pix_addr + 1'b1; // Step after each write
            if (vsync_rise) begin
                state    <= FIRST_BYTE;
                pix_addr <= '0;              // New frame starts at address 0
            end else begin
                case (state)
                    WAIT_FRAME:  state <= WAIT_FRAME;
                    FIRST_BYTE:  if (byte_take) state <= SECOND_BYTE;
                    SECOND_BYTE: begin
                        if (byte_take) begin
                            pix_we <= 1'b1;  // Write on the cycle after byte two
                            state  <= FIRST_BYTE;
                        end else if (!cam_href) begin
                            state  <= FIRST_BYTE; // Line ended mid pixel
                        end
                    end
                    default:     state <= WAIT_FRAME;
                endcase
            end
        end
    end

    // Pixel payload
    always_ff @(posedge clk) begin
        if (state == FIRST_BYTE && byte_take)
            first_byte <= cam_data;
        if (state == SECOND_BYTE && byte_take)
            pix_gray <= gray_sum[5:2];       // Divide by 4, truncated
    end

endmodule

// ==== design/cctv_pkg.sv ====
package cctv_pkg;

    //////////////////////////////
    // Vector types
    typedef logic [3:0]  gray_t;     // Gray value or one color channel
    typedef logic [16:0] pix_addr_t; // Frame buffer address
    typedef logic [16:0] diff_cnt_t; // Differing pixels in one frame
    typedef logic [9:0]  coord_t;    // VGA counter or coordinate
    typedef logic [7:0]  cam_byte_t; // Camera data byte

    typedef enum logic [1:0] {
        WAIT_FRAME,                  // Idle until the first frame boundary
        FIRST_BYTE,                  // Expecting R5 and G high 3
        SECOND_BYTE                  // Expecting G low 3 and B5
    } capture_state_t;

    //////////////////////////////
    // Stored image
    localparam int IMG_W     = 320;
    localparam int IMG_H     = 240;
    localparam int PIX_COUNT = IMG_W * IMG_H;

    //////////////////////////////
    // 640x480 VGA timing
    localparam coord_t H_ACTIVE = 640;
    localparam coord_t H_FRONT  = 16;
    localparam coord_t H_SYNC   = 96;
    localparam coord_t H_TOTAL  = 800;
    localparam coord_t V_ACTIVE = 480;
    localparam coord_t V_FRONT  = 10;
    localparam coord_t V_SYNC   = 2;
    localparam coord_t V_TOTAL  = 525;

    // Detection and display pipeline
    localparam int DET_SHIFT  = 6;   // Frame limit is detection_threshold << DET_SHIFT
    localparam int PIPE_DELAY = 2;   // Counter to color and sync latency

endpackage

// ==== design/cctv_top.sv ====
`timescale 1ns/1ns

module cctv_top import cctv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cam_byte_t  cam_data,
    input  logic       cam_href,
    input  logic       cam_vsync,
    input  logic       cam_pixel_strobe,
    input  gray_t      pixel_threshold,     // Per pixel difference threshold
    input  logic [7:0] detection_threshold, // Motion sensitivity
    output gray_t      red,
    output gray_t      green,
    output gray_t      blue,
    output logic       h_sync,
    output logic       v_sync,
    output logic [7:0] motion_led,
    output logic       motion_detected
);

    logic      pix_we;
    pix_addr_t pix_addr;
    gray_t     pix_gray;
    logic      write_sel;
    logic      frame_done;
    gray_t     prev_gray;
    logic      prev_valid;
    gray_t     cur_gray;
    pix_addr_t disp_addr;
    gray_t     disp_gray_cur;
    gray_t     disp_gray_prev;
    coord_t    h_count;
    coord_t    v_count;
    logic      display_enable;
    logic      h_sync_raw;
    logic      v_sync_raw;

    assign motion_led = {8{motion_detected}}; // All LEDs follow the flag

    //////////////////////////////
    // Capture, storage and detection
    camera_capture camera_capture_i (
        .clk              (clk),
        .rst              (rst),
        .cam_data         (cam_data),
        .cam_href         (cam_href),
        .cam_vsync        (cam_vsync),
        .cam_pixel_strobe (cam_pixel_strobe),
        .pix_we           (pix_we),
        .pix_addr         (pix_addr),
        .pix_gray         (pix_gray),
        .write_sel        (write_sel),
        .frame_done       (frame_done)
    );

    frame_store frame_store_i (
        .clk            (clk),
        .pix_we         (pix_we),
        .pix_addr       (pix_addr),
        .pix_gray       (pix_gray),
        .write_sel      (write_sel),
        .prev_gray      (prev_gray),
        .prev_valid     (prev_valid),
        .cur_gray       (cur_gray),
        .disp_addr      (disp_addr),       // Display side read
        .disp_gray_cur  (disp_gray_cur),
        .disp_gray_prev (disp_gray_prev)
    );

    motion_detector motion_detector_i (
        .clk                 (clk),
        .rst                 (rst),
        .prev_valid          (prev_valid),
        .cur_gray            (cur_gray),
        .prev_gray           (prev_gray),
        .pixel_threshold     (pixel_threshold),
        .detection_threshold (detection_threshold),
        .frame_done          (frame_done),
        .motion_detected     (motion_detected)
    );

    //////////////////////////////
    // Display
    vga_timing vga_timing_i (
        .clk            (clk),
        .rst            (rst),
        .h_count        (h_count),
        .v_count        (v_count),
        .display_enable (display_enable),
        .h_sync_raw     (h_sync_raw),
        .v_sync_raw     (v_sync_raw)
    );

    vga_pixel_out vga_pixel_out_i (
        .clk             (clk),
        .rst             (rst),
        .h_count         (h_count),
        .v_count         (v_count),
        .display_enable  (display_enable),
        .h_sync_raw      (h_sync_raw),
        .v_sync_raw      (v_sync_raw),
        .disp_addr       (disp_addr),
        .disp_gray_cur   (disp_gray_cur),
        .disp_gray_prev  (disp_gray_prev),
        .pixel_threshold (pixel_threshold),
        .motion_detected (motion_detected),
        .red             (red),
        .green           (green),
        .blue            (blue),
        .h_sync          (h_sync),
        .v_sync          (v_sync)
    );

endmodule

// ==== design/frame_store.sv ====
`timescale 1ns/1ns

module frame_store import cctv_pkg::*; (
    input  logic      clk,
    input  logic      pix_we,
    input  pix_addr_t pix_addr,
    input  gray_t     pix_gray,
    input  logic      write_sel,
    output gray_t     prev_gray,
    output logic      prev_valid,
    output gray_t     cur_gray,
    input  pix_addr_t disp_addr,
    output gray_t     disp_gray_cur,
    output gray_t     disp_gray_prev
);

    gray_t frame_0 [PIX_COUNT];              // Written while write_sel is 0
    gray_t frame_1 [PIX_COUNT];              // Written while write_sel is 1
    gray_t cmp_0;
    gray_t cmp_1;
    gray_t disp_0;
    gray_t disp_1;
    logic  sel_q;                            // write_sel aligned with read data

    always_ff @(posedge clk) begin
        if (pix_we && !write_sel)
            frame_0[pix_addr] <= pix_gray;
        cmp_0  <= frame_0[pix_addr];
        disp_0 <= frame_0[disp_addr];
    end

    always_ff @(posedge clk) begin
        if (pix_we && write_sel)
            frame_1[pix_addr] <= pix_gray;
        cmp_1  <= frame_1[pix_addr];
        disp_1 <= frame_1[disp_addr];
    end

    // Current pixel delayed to meet the previous frame read
    always_ff @(posedge clk) begin
        prev_valid <= pix_we;
        cur_gray   <= pix_gray;
        sel_q      <= write_sel;
    end

    // The buffer not being written holds the last full frame
    assign prev_gray      = sel_q ? cmp_0  : cmp_1;
    assign disp_gray_cur  = sel_q ? disp_0 : disp_1;
    assign disp_gray_prev = sel_q ? disp_1 : disp_0;

endmodule

// ==== design/motion_detector.sv ====
`timescale 1ns/1ns

module motion_detector import cctv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       prev_valid,
    input  gray_t      cur_gray,
    input  gray_t      prev_gray,
    input  gray_t      pixel_threshold,
    input  logic [7:0] detection_threshold,
    input  logic       frame_done,
    output logic       motion_detected
);

    gray_t      abs_diff;
    logic       pix_hit;
    diff_cnt_t  run_cnt;                     // Frame in progress
    diff_cnt_t  frame_cnt;                   // Last finished frame
    diff_cnt_t  det_limit;
    logic       decide;                      // Decision cycle after frame_done
    logic [1:0] frame_age;                   // Boundaries seen, saturates at 3

    assign abs_diff  = (cur_gray > prev_gray) ? cur_gray - prev_gray
                                              : prev_gray - cur_gray;
    assign pix_hit   = prev_valid && (abs_diff > pixel_threshold);
    assign det_limit = diff_cnt_t'(detection_threshold) << DET_SHIFT;

    always_ff @(posedge clk) begin
        if (rst) begin
            run_cnt         <= '0;
            frame_cnt       <= '0;
            decide          <= 1'b0;
            frame_age       <= '0;
            motion_detected <= 1'b0;
        end else begin
            decide <= frame_done;
            if (frame_done) begin
                frame_cnt <= run_cnt;        // Latch and restart
                run_cnt   <= '0;
                if (frame_age != 2'd3)
                    frame_age <= frame_age + 1'b1;
            end else if (pix_hit) begin
                run_cnt <= run_cnt + 1'b1;
            end
            // Two stored frames are needed before a count means anything
            if (decide)
                motion_detected <= (frame_age == 2'd3) && (frame_cnt > det_limit);
        end
    end

endmodule

// ==== design/vga_pixel_out.sv ====
`timescale 1ns/1ns

module vga_pixel_out import cctv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  coord_t    h_count,
    input  coord_t    v_count,
    input  logic      display_enable,
    input  logic      h_sync_raw,
    input  logic      v_sync_raw,
    output pix_addr_t disp_addr,
    input  gray_t     disp_gray_cur,
    input  gray_t     disp_gray_prev,
    input  gray_t     pixel_threshold,
    input  logic      motion_detected,
    output gray_t     red,
    output gray_t     green,
    output gray_t     blue,
    output logic      h_sync,
    output logic      v_sync
);

    logic                  in_top;
    logic                  left_top;
    logic                  right_top;
    coord_t                col;             // Column inside the stored image
    logic                  left_q;          // Quadrant tags aligned with read data
    logic                  right_q;
    logic [PIPE_DELAY-1:0] hs_pipe;
    logic [PIPE_DELAY-1:0] vs_pipe;
    gray_t                 abs_diff;
    logic                  diff_hit;

    //////////////////////////////
    // Quadrant decode and read address
    assign in_top    = display_enable && (v_count < coord_t'(IMG_H));
    assign left_top  = in_top && (h_count < coord_t'(IMG_W));
    assign right_top = in_top && !left_top;
    assign col       = right_top ? h_count - coord_t'(IMG_W) : h_count;
    assign disp_addr = in_top ? pix_addr_t'(v_count) * pix_addr_t'(IMG_W) + pix_addr_t'(col)
                              : '0;

    assign abs_diff = (disp_gray_cur > disp_gray_prev) ? disp_gray_cur - disp_gray_prev
                                                       : disp_gray_prev - disp_gray_cur;
    assign diff_hit = abs_diff > pixel_threshold;

    // Sync delay line and stage one tags
    always_ff @(posedge clk) begin
        if (rst) begin
            hs_pipe <= '1;                  // Syncs idle high
            vs_pipe <= '1;
            left_q  <= 1'b0;
            right_q <= 1'b0;
        end else begin
            hs_pipe <= {hs_pipe[PIPE_DELAY-2:0], h_sync_raw};
            vs_pipe <= {vs_pipe[PIPE_DELAY-2:0], v_sync_raw};
            left_q  <= left_top;
            right_q <= right_top;
        end
    end

    assign h_sync = hs_pipe[PIPE_DELAY-1];
    assign v_sync = vs_pipe[PIPE_DELAY-1];

    //////////////////////////////
    // Stage two color
    always_ff @(posedge clk) begin
        if (rst) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (left_q) begin
            red   <= disp_gray_cur;         // Last full frame in gray
            green <= disp_gray_cur;
            blue  <= disp_gray_cur;
        end else if (right_q && diff_hit) begin
            red   <= '1;
            green <= motion_detected ? '0 : '1; // Red alarm, else white
            blue  <= motion_detected ? '0 : '1;
        end else begin
            red   <= '0;                    // Unchanged, bottom half, blanking
            green <= '0;
            blue  <= '0;
        end
    end

endmodule

// ==== design/vga_timing.sv ====
`timescale 1ns/1ns

module vga_timing import cctv_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    output coord_t h_count,
    output coord_t v_count,
    output logic   display_enable,
    output logic   h_sync_raw,
    output logic   v_sync_raw
);

    logic h_last;
    logic v_last;

    assign h_last = (h_count == H_TOTAL - 1'b1);
    assign v_last = (v_count == V_TOTAL - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
            v_count <= v_last ? '0 : v_count + 1'b1; // Next line or wrap frame
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign display_enable = (h_count < H_ACTIVE) && (v_count < V_ACTIVE);

    // Active-low pulses, 656..751 and lines 490..491
    assign h_sync_raw = ~((h_count >= H_ACTIVE + H_FRONT) &&
                          (h_count <  H_ACTIVE + H_FRONT + H_SYNC));
    assign v_sync_raw = ~((v_count >= V_ACTIVE + V_FRONT) &&
                          (v_count <  V_ACTIVE + V_FRONT + V_SYNC));

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the CCTV testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_cctv -f cctv_top.f -o tb_cctv
./obj_dir/tb_cctv | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"

// ==== tb/tb_cctv.sv ====
`timescale 1ns/1ns

module tb_cctv import cctv_pkg::*; ();

    //////////////////////////////
    // Run limit and DUT signals
    localparam int FRAME_CYCLES = PIX_COUNT * 2 + 4000;          // Byte pairs, line gaps, vsync
    localparam int VGA_CYCLES   = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int LIMIT_NS     = (6 * FRAME_CYCLES + 9 * VGA_CYCLES) * 10; // 6 sent, 9 watched

    logic       clk = 1'b0;
    logic       rst;
    cam_byte_t  cam_data;
    logic       cam_href;
    logic       cam_vsync;
    logic       cam_pixel_strobe;
    gray_t      pixel_threshold;
    logic [7:0] detection_threshold;
    gray_t      red;
    gray_t      green;
    gray_t      blue;
    logic       h_sync;
    logic       v_sync;
    logic [7:0] motion_led;
    logic       motion_detected;

    int          cyc = 0;                 // Clock cycles since time 0
    logic [31:0] lcg_state = 32'haa23cfc7;
    logic [15:0] cur_pix  [PIX_COUNT];    // RGB565 model of the last frame sent
    logic [15:0] prev_pix [PIX_COUNT];    // The frame before it
    logic [15:0] next_pix [PIX_COUNT];    // Frame being prepared

    cctv_top cctv_top_i (.*);

    always #5 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        #(LIMIT_NS);
        $display("Timeout: the tests did not finish within %0d ns", LIMIT_NS);
        $display("Test failed");
        $fatal(1);
    end

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // Reference model
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Top 4 bits of R, G and B, then (r + 2g + b) / 4
    function automatic gray_t gray_of(input logic [15:0] pix);
        int sum;
        sum = int'(pix[15:12]) + 2 * int'(pix[10:7]) + int'(pix[4:1]);
        return gray_t'(sum / 4);
    endfunction

    function automatic logic [11:0] expected_rgb(input int row, input int col, input logic motion);
        gray_t cur_g;
        gray_t prev_g;
        int    diff;
        if (row >= IMG_H)
            return 12'h000;                  // Bottom half stays dark
        if (col < IMG_W) begin
            cur_g = gray_of(cur_pix[row * IMG_W + col]);
            return {cur_g, cur_g, cur_g};
        end
        cur_g  = gray_of(cur_pix[row * IMG_W + col - IMG_W]);
        prev_g = gray_of(prev_pix[row * IMG_W + col - IMG_W]);
        diff   = int'(cur_g) - int'(prev_g);
        if (diff < 0)
            diff = -diff;
        if (diff <= int'(pixel_threshold))
            return 12'h000;
        return motion ? 12'hf00 : 12'hfff;   // Red alarm or white
    endfunction

    task automatic fill_random();
        int i;
        for (i = 0; i < PIX_COUNT; i++) begin
            lcg_state   = lcg_next(lcg_state);
            next_pix[i] = lcg_state[31:16];  // Upper bits
        end
    endtask

    // Copy of the last frame with count pixels swung by 8 or more levels
    task automatic change_pixels(input int count);
        int i;
        for (i = 0; i < PIX_COUNT; i++)
            next_pix[i] = cur_pix[i];
        for (i = 0; i < count; i++)
            next_pix[i * 127] = (gray_of(cur_pix[i * 127]) < 8) ? 16'hffff : 16'h0000;
    endtask

    //////////////////////////////
    // Camera driver
    task automatic pulse_vsync();
        @(posedge clk);
        #1 cam_vsync = 1'b1;
        repeat (4) @(posedge clk);
        #1 cam_vsync = 1'b0;
        repeat (4) @(posedge clk);           // Decision settles 3 cycles after the edge
        #1;
    endtask

    task automatic send_frame();
        int i;
        for (i = 0; i < PIX_COUNT; i++) begin
            prev_pix[i] = cur_pix[i];
            cur_pix[i]  = next_pix[i];
        end
        for (i = 0; i < PIX_COUNT; i++) begin
            @(posedge clk);
            #1;
            cam_href         = 1'b1;
            cam_pixel_strobe = 1'b1;
            cam_data         = next_pix[i][15:8]; // R5 and G high 3
            @(posedge clk);
            #1 cam_data = next_pix[i][7:0];       // G low 3 and B5
            if (i % IMG_W == IMG_W - 1) begin
                @(posedge clk);
                #1;
                cam_href         = 1'b0;          // Short gap between lines
                cam_pixel_strobe = 1'b0;
                repeat (3) @(posedge clk);
            end
        end
        repeat (8) @(posedge clk);
        pulse_vsync();                            // Closes the frame
    endtask

    //////////////////////////////
    // VGA sampling
    task automatic wait_sync_edge(input logic vertical, input logic level);
        logic last_s;
        logic now_s;
        logic found;
        last_s = vertical ? v_sync : h_sync;
        do begin
            @(negedge clk);
            now_s  = vertical ? v_sync : h_sync;
            found  = (last_s != level) && (now_s == level);
            last_s = now_s;
        end while (!found);
    endtask

    task automatic check_display(input string name, input logic motion);
        int row;
        int col;
        wait_sync_edge(1'b1, 1'b1);              // Line 492 begins
        repeat (32) wait_sync_edge(1'b0, 1'b0);  // Back porch lines
        for (row = 0; row < int'(V_ACTIVE); row++) begin
            wait_sync_edge(1'b0, 1'b0);
            repeat (int'(H_TOTAL - H_ACTIVE - H_FRONT) - 1) @(negedge clk); // 144 to x = 0
            for (col = 0; col < int'(H_ACTIVE); col++) begin
                @(negedge clk);
                check_eq(name, expected_rgb(row, col, motion), {red, green, blue});
            end
        end
    endtask

    //////////////////////////////
    // Directed tests
    task automatic reset_and_check();
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_eq("reset", 23'h600000, {h_sync, v_sync, red, green, blue, motion_detected,
                                       motion_led});
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_eq("reset", 23'h600000, {h_sync, v_sync, red, green, blue, motion_detected,
                                       motion_led});
    endtask

    task automatic test_vga_timing();
        int t0;
        wait_sync_edge(1'b0, 1'b0);
        t0 = cyc;
        wait_sync_edge(1'b0, 1'b1);
        check_eq("vga_h_pulse", H_SYNC, cyc - t0);
        wait_sync_edge(1'b0, 1'b0);
        check_eq("vga_h_period", H_TOTAL, cyc - t0);
        wait_sync_edge(1'b1, 1'b0);
        t0 = cyc;
        wait_sync_edge(1'b1, 1'b1);
        check_eq("vga_v_pulse", int'(V_SYNC) * int'(H_TOTAL), cyc - t0);
        wait_sync_edge(1'b1, 1'b0);
        check_eq("vga_v_period", VGA_CYCLES, cyc - t0);
    endtask

    task automatic test_gray_display();
        pulse_vsync();                           // First boundary starts capture
        fill_random();
        send_frame();
        send_frame();                            // Same frame again
        check_eq("gray_display", 9'h000, {motion_led, motion_detected});
        check_display("gray_display", 1'b0);
    endtask

    task automatic test_motion_decision();
        int limit;
        limit = int'(detection_threshold) << DET_SHIFT;
        change_pixels(limit + 88);
        send_frame();
        check_eq("motion_set", 9'h1ff, {motion_led, motion_detected});
        check_display("diff_map_red", 1'b1);
        change_pixels(0);
        send_frame();
        check_eq("motion_clear", 9'h000, {motion_led, motion_detected});
        change_pixels(limit);                    // Count equal to the limit
        send_frame();
        check_eq("motion_at_limit", 9'h000, {motion_led, motion_detected});
        check_display("diff_map_white", 1'b0);
    endtask

    task automatic test_first_frame();
        @(posedge clk);
        #1;
        reset_and_check();
        pulse_vsync();
        fill_random();                           // Unlike both stored buffers
        send_frame();
        check_eq("first_frame", 9'h000, {motion_led, motion_detected});
    endtask

    initial begin
        rst                 = 1'b1;
        cam_data            = '0;
        cam_href            = 1'b0;
        cam_vsync           = 1'b0;
        cam_pixel_strobe    = 1'b0;
        pixel_threshold     = 4'd3;
        detection_threshold = 8'd8;             // Limit of 512 pixels
        reset_and_check();
        test_vga_timing();
        test_gray_display();
        test_motion_decision();
        test_first_frame();
        $display("Test completed successfully");
        $finish;
    end

endmodule
